// File: filelist.f
verilog/spi_pkg.sv
verilog/spi_xfer_if.sv
verilog/spi_reg_decode.sv
verilog/spi_shift_engine.sv
verilog/spi_rx_capture.sv
verilog/spi_master.sv
testbench/spi_master_sva.sv
testbench/tb_spi_master.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_spi_master
FILELIST  ?= filelist.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)
LOG  := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: testbench/tb_spi_master.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// drives the cpu port, models one spi slave per byte
// stops at the first wrong value, watchdog bounds the run
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module tb_spi_master
  import spi_pkg::*;
;

  localparam longint CLK_NS      = 100;
  localparam int     N_XFER      = 24;                               // random mode transfers
  localparam longint WATCHDOG_NS = 64'd40 * 16 * 33 * CLK_NS + 64'd500000;

  logic              clk;
  logic              rst_n;
  logic              en;
  logic              wr;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] rdata;
  logic              irq;
  logic              spi_clk;
  logic              mosi;
  logic              miso;
  logic              ss_n;
  logic [DATA_W-1:0] slave_rx;     // byte last captured by the slave
  int                sclk_edges;   // every o_spi_clk change

  spi_master u_dut (
    .i_clk (clk), .i_sclk (rst_n), .i_en (en), .i_wr (wr), .i_addr (addr),
    .i_data (wdata), .o_data (rdata), .o_int (irq), .o_spi_clk (spi_clk),
    .o_mosi (mosi), .i_miso (miso), .o_ss_n (ss_n)
  );

  always #(CLK_NS / 2) clk = ~clk;

  always @(spi_clk) sclk_edges++;  // idle test looks for stray edges

  // expected o_data from the register map
  function automatic logic [DATA_W-1:0] ref_read(input logic [ADDR_W-1:0] a,
      input logic [DATA_W-1:0] ctrl, input logic busy, input logic [DATA_W-1:0] rx);
    logic [DATA_W-1:0] v;
    v = '0;
    if (a == ADDR_STATUS) v[STATUS_BUSY_BIT] = busy;
    else if (a == ADDR_DATA_IN) v = rx;
    else if (a == ADDR_CTRL) v = ctrl;
    return v;  // reserved addresses stay zero
  endfunction

  task automatic fail(input string msg);
    $display("error at %0t ns: %s", $time, msg);
    $display("RESULT: FAIL");
    $fatal(1, "test stopped");
  endtask

  task automatic check8(input string name, input logic [DATA_W-1:0] got,
                        input logic [DATA_W-1:0] exp);
    assert (got === exp) else begin
      $display("mismatch at %0t ns: %s got %02h expected %02h", $time, name, got, exp);
      $display("RESULT: FAIL");
      $fatal(1, "value check failed");
    end
  endtask

  task automatic bus_write(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
    @(posedge clk);
    en    <= 1'b1;
    wr    <= 1'b1;
    addr  <= a;
    wdata <= d;
    @(posedge clk);  // dut takes the write here
    en <= 1'b0;
    wr <= 1'b0;
  endtask

  task automatic read_check(input string name, input logic [ADDR_W-1:0] a,
                            input logic [DATA_W-1:0] exp);
    @(posedge clk);
    en   <= 1'b1;
    wr   <= 1'b0;
    addr <= a;
    @(posedge clk);
    en <= 1'b0;
    @(negedge clk);  // o_data settled
    check8(name, rdata, exp);
  endtask

  // slave side of one byte, also times every half period
  task automatic spi_slave(input logic cpol, input logic cpha, input int div,
                           input logic [DATA_W-1:0] tx);
    time t_last;
    int  i;
    slave_rx = '0;
    t_last   = 0;
    if (!cpha) miso <= tx[7];  // msb before first edge
    for (i = 0; i < 16; i++) begin
      @(spi_clk);
      if (i > 0)
        assert (($time - t_last) == (div + 1) * CLK_NS)
          else fail("spi clock half period differs from clk_div+1 cycles");
      t_last = $time;
      if (i % 2 == 0) begin  // leading edge
        assert (spi_clk === ~cpol) else fail("leading edge has wrong direction");
        if (cpha) miso <= tx[7-i/2];
        else slave_rx = {slave_rx[6:0], mosi};
      end else begin  // trailing edge
        if (cpha) slave_rx = {slave_rx[6:0], mosi};
        else if (i < 15) miso <= tx[6-i/2];
      end
    end
  endtask

  task automatic wait_int(input int limit);
    int n;
    n = 0;
    while (irq !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > limit) fail("interrupt did not rise after a transfer");
    end
  endtask

  // one full byte: config, start, busy, irq, data in, irq clear
  task automatic run_xfer(input logic cpol, input logic cpha, input int div,
                          input logic [DATA_W-1:0] mtx, input logic extra_wr);
    logic [DATA_W-1:0] ctrl;
    logic [DATA_W-1:0] stx;
    ctrl = {5'(div), 1'b1, cpol, cpha};
    stx  = 8'($urandom);
    bus_write(ADDR_CTRL, ctrl);
    @(negedge clk);
    assert (spi_clk === cpol) else fail("spi clock idle level differs from cpol");
    assert (ss_n === 1'b0) else fail("ss_n not low with slave select enabled");
    fork
      spi_slave(cpol, cpha, div, stx);
      begin
        bus_write(ADDR_DATA_OUT, mtx);
        read_check("status busy", ADDR_STATUS, ref_read(ADDR_STATUS, ctrl, 1'b1, '0));
        if (extra_wr) bus_write(ADDR_DATA_OUT, ~mtx);  // must be dropped
        wait_int(16 * (div + 1) + 40);
      end
    join
    check8("slave mosi byte", slave_rx, mtx);
    read_check("data in", ADDR_DATA_IN, ref_read(ADDR_DATA_IN, ctrl, 1'b0, stx));
    assert (irq === 1'b0) else fail("interrupt stayed high after data in read");
    read_check("status idle", ADDR_STATUS, ref_read(ADDR_STATUS, ctrl, 1'b0, '0));
    assert (spi_clk === cpol) else fail("spi clock not back at cpol after transfer");
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("error at %0t ns: watchdog expired, test did not finish", $time);
    $display("RESULT: FAIL");
    $fatal(1, "timeout");
  end

  initial begin
    logic [DATA_W-1:0] v;
    int                k;
    int                edges0;
    void'($urandom(32'hbde8));
    clk   = 1'b0;
    rst_n = 1'b0;
    en    = 1'b0;
    wr    = 1'b0;
    addr  = '0;
    wdata = '0;
    miso  = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    assert (ss_n === 1'b1 && irq === 1'b0) else fail("reset state of ss_n or irq wrong");
    read_check("ctrl after reset", ADDR_CTRL, '0);
    for (k = 0; k < 8; k++) begin  // control readback
      v = 8'($urandom);
      bus_write(ADDR_CTRL, v);
      @(negedge clk);
      assert (ss_n === ~v[CTRL_SS_BIT]) else fail("ss_n does not follow the written select bit");
      read_check("ctrl readback", ADDR_CTRL, ref_read(ADDR_CTRL, v, 1'b0, '0));
    end
    for (k = 4; k < 16; k++) read_check("reserved", 4'(k), ref_read(4'(k), v, 1'b0, '0));
    for (k = 0; k < N_XFER; k++)  // every mode several times
      run_xfer(k[1], k[0], int'($urandom_range(0, 31)), 8'($urandom), 1'b0);
    run_xfer(1'b0, 1'b1, 3, 8'h5a, 1'b1);  // write while busy
    edges0 = sclk_edges;
    repeat (60) @(negedge clk);
    assert (sclk_edges == edges0 && irq === 1'b0) else fail("busy write started a transfer");
    bus_write(ADDR_CTRL, 8'h00);  // ss off
    @(negedge clk);
    assert (ss_n === 1'b1) else fail("ss_n not high with slave select disabled");
    edges0 = sclk_edges;
    bus_write(ADDR_DATA_OUT, 8'hc3);
    repeat (60) @(negedge clk);
    assert (sclk_edges == edges0 && irq === 1'b0)
      else fail("write with ss off started a transfer");
    read_check("status ss off", ADDR_STATUS, '0);
    read_check("data out kept", ADDR_DATA_OUT, 8'h5a);  // both dropped writes left it
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// File: testbench/spi_master_sva.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// handshake and pin rules, bound into spi_master
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module spi_master_sva
  import spi_pkg::*;
(
  input logic              i_clk,      // system clock
  input logic              i_sclk,     // reset, async active low
  input logic              i_en,       // bus access
  input logic              i_wr,       // 1 write, 0 read
  input logic [ADDR_W-1:0] i_addr,     // register address
  input logic [DATA_W-1:0] i_data,     // write data
  input logic              req,        // handshake request
  input logic              ack,        // handshake acknowledge
  input logic              cpol,       // idle level
  input logic              o_spi_clk,  // spi clock pin
  input logic              o_ss_n      // slave select pin
);

  // req held until the engine answers
  a_req_hold: assert property (@(posedge i_clk) disable iff (!i_sclk)
    req && !ack |=> req) else $error("req dropped before ack");

  a_ack_req: assert property (@(posedge i_clk) disable iff (!i_sclk)
    $rose(ack) |-> req) else $error("ack rose without req");

  a_idle_clk: assert property (@(posedge i_clk) disable iff (!i_sclk)
    !(req || ack) |-> o_spi_clk == cpol) else $error("spi clock not at cpol while idle");

  // accepted control write sets the pin to the inverted select bit
  a_ss_pin: assert property (@(posedge i_clk) disable iff (!i_sclk)
    i_en && i_wr && (i_addr == ADDR_CTRL) && !(req || ack)
    |=> o_ss_n == !$past(i_data[CTRL_SS_BIT]))
    else $error("ss_n does not follow control bit");

endmodule

bind spi_master spi_master_sva u_sva (
  .i_clk     (i_clk),
  .i_sclk    (i_sclk),
  .i_en      (i_en),
  .i_wr      (i_wr),
  .i_addr    (i_addr),
  .i_data    (i_data),
  .req       (u_xfer.req),
  .ack       (u_xfer.ack),
  .cpol      (u_xfer.cpol),
  .o_spi_clk (o_spi_clk),
  .o_ss_n    (o_ss_n)
);

// File: verilog/spi_master.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// byte-wide spi master, single slave, no fifo
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module spi_master
  import spi_pkg::*;
(
  input  logic              i_clk,      // system clock
  input  logic              i_sclk,     // reset, async active low
  input  logic              i_en,       // bus access
  input  logic              i_wr,       // 1 write, 0 read
  input  logic [ADDR_W-1:0] i_addr,     // status, data out, data in, ctrl
  input  logic [DATA_W-1:0] i_data,     // write data
  output logic [DATA_W-1:0] o_data,     // read data, 1 clk latency
  output logic              o_int,      // byte done
  output logic              o_spi_clk,  // spi clock
  output logic              o_mosi,     // master out slave in
  input  logic              i_miso,     // master in slave out
  output logic              o_ss_n      // slave select, active low
);

  logic              busy;        // capture to decode
  logic [DATA_W-1:0] rx_data;     // data in register
  logic              rd_data_in;  // irq clear strobe

  spi_xfer_if u_xfer ();

  spi_reg_decode u_decode (
    .i_clk        (i_clk),
    .i_sclk       (i_sclk),
    .i_en         (i_en),
    .i_wr         (i_wr),
    .i_addr       (i_addr),
    .i_data       (i_data),
    .i_busy       (busy),
    .i_rx_data    (rx_data),
    .o_data       (o_data),
    .o_ss_n       (o_ss_n),
    .o_rd_data_in (rd_data_in),
    .xfer         (u_xfer.ctrl)
  );

  spi_shift_engine u_engine (
    .i_clk     (i_clk),
    .i_sclk    (i_sclk),
    .i_miso    (i_miso),
    .o_spi_clk (o_spi_clk),
    .o_mosi    (o_mosi),
    .xfer      (u_xfer.eng)
  );

  spi_rx_capture u_capture (
    .i_clk        (i_clk),
    .i_sclk       (i_sclk),
    .i_rd_data_in (rd_data_in),
    .o_busy       (busy),
    .o_rx_data    (rx_data),
    .o_int        (o_int),
    .xfer         (u_xfer.mon)
  );

endmodule

// File: verilog/spi_rx_capture.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// irq is sticky, only a data in read clears it
// a new completion wins over a same-cycle read
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module spi_rx_capture
  import spi_pkg::*;
(
  input  logic              i_clk,         // system clock
  input  logic              i_sclk,        // reset, async active low
  input  logic              i_rd_data_in,  // cpu reads data in
  output logic              o_busy,        // handshake open
  output logic [DATA_W-1:0] o_rx_data,     // data in register
  output logic              o_int,         // byte done interrupt
  spi_xfer_if.mon           xfer           // observed handshake
);

  logic              ack_d;     // ack one clk ago
  logic              ack_rise;  // transfer just completed
  logic              int_q;     // sticky interrupt
  logic [DATA_W-1:0] rx_q;      // received byte

  assign ack_rise = xfer.ack & ~ack_d;

  always_ff @(posedge i_clk or negedge i_sclk) begin
    if (!i_sclk) begin
      ack_d <= 1'b0;
    end else begin
      ack_d <= xfer.ack;
    end
  end

  always_ff @(posedge i_clk or negedge i_sclk) begin
    if (!i_sclk) begin
      int_q <= 1'b0;
    end else if (ack_rise) begin
      int_q <= 1'b1;  // up the clk after ack
    end else if (i_rd_data_in) begin
      int_q <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (ack_rise) begin
      rx_q <= xfer.rx_byte;  // stable while ack high
    end
  end

  // busy spans req rise through ack fall
  assign o_busy    = xfer.req | xfer.ack;
  assign o_rx_data = rx_q;
  assign o_int     = int_q;

endmodule

// File: verilog/spi_shift_engine.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// one msb-first byte per req, all four spi modes
// i_miso must already be in the i_clk domain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module spi_shift_engine
  import spi_pkg::*;
(
  input  logic     i_clk,      // system clock
  input  logic     i_sclk,     // reset, async active low
  input  logic     i_miso,     // serial data from slave
  output logic     o_spi_clk,  // spi clock to slave
  output logic     o_mosi,     // serial data to slave
  spi_xfer_if.eng  xfer        // acknowledge side of handshake
);

  logic [ST_W-1:0]      state_q;     // engine fsm
  logic [DIV_W-1:0]     div_cnt_q;   // clocks within a half period
  logic [BIT_CNT_W-1:0] edge_cnt_q;  // sclk edges done so far
  logic                 sclk_q;      // sclk while shifting
  logic                 ack_q;       // handshake ack
  logic [DATA_W-1:0]    tx_sh_q;     // outgoing bits, msb on the pin
  logic [DATA_W-1:0]    rx_sh_q;     // incoming bits
  logic                 start;       // req accepted this cycle
  logic                 spi_edge;    // sclk toggles this cycle
  logic                 leading;     // edge leaves the idle level
  logic                 do_sample;   // capture miso
  logic                 do_shift;    // present next mosi bit

  assign start    = (state_q == ST_IDLE) && xfer.req;
  assign spi_edge = (state_q == ST_SHIFT) && (div_cnt_q == xfer.clk_div);
  assign leading  = ~edge_cnt_q[0];  // even edges lead

  // cpha 0: sample leading, shift trailing
  // cpha 1: shift leading, sample trailing. The first leading edge
  // keeps the msb that was loaded with the byte
  assign do_sample = spi_edge && (xfer.cpha ? ~leading : leading);
  assign do_shift  = spi_edge && (xfer.cpha ? (leading && (edge_cnt_q != '0))
                                            : ~leading);

  always_ff @(posedge i_clk or negedge i_sclk) begin
    if (!i_sclk) begin
      state_q    <= ST_IDLE;
      div_cnt_q  <= '0;
      edge_cnt_q <= '0;
      sclk_q     <= 1'b0;
      ack_q      <= 1'b0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (xfer.req) begin
            state_q    <= ST_SHIFT;
            div_cnt_q  <= '0;
            edge_cnt_q <= '0;
            sclk_q     <= xfer.cpol;  // start from idle level
          end
        end
        ST_SHIFT: begin
          if (spi_edge) begin
            div_cnt_q  <= '0;
            sclk_q     <= ~sclk_q;
            edge_cnt_q <= edge_cnt_q + 1'b1;  // wraps after edge 15
            if (edge_cnt_q == LAST_EDGE) begin
              state_q <= ST_DONE;
            end
          end else begin
            div_cnt_q <= div_cnt_q + 1'b1;
          end
        end
        ST_DONE: begin
          ack_q   <= 1'b1;  // one clk after last edge, phase 2
          state_q <= ST_ACK;
        end
        ST_ACK: begin
          if (!xfer.req) begin
            ack_q   <= 1'b0;  // phase 4
            state_q <= ST_IDLE;
          end
        end
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // data path
  always_ff @(posedge i_clk) begin
    if (start) begin
      tx_sh_q <= xfer.tx_byte;  // msb visible before first edge
    end else if (do_shift) begin
      tx_sh_q <= {tx_sh_q[DATA_W-2:0], 1'b0};
    end
    if (do_sample) begin
      rx_sh_q <= {rx_sh_q[DATA_W-2:0], i_miso};  // pre-edge value
    end
  end

  // sclk sits at cpol whenever no byte is moving
  assign o_spi_clk    = (state_q == ST_SHIFT) ? sclk_q : xfer.cpol;
  assign o_mosi       = tx_sh_q[DATA_W-1];
  assign xfer.ack     = ack_q;
  assign xfer.rx_byte = rx_sh_q;

endmodule

// File: verilog/spi_reg_decode.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// cpu register port, reads land in o_data 1 clk later
// control and data out writes are dropped while busy
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module spi_reg_decode
  import spi_pkg::*;
(
  input  logic              i_clk,         // system clock
  input  logic              i_sclk,        // reset, async active low
  input  logic              i_en,          // bus access this cycle
  input  logic              i_wr,          // 1 write, 0 read
  input  logic [ADDR_W-1:0] i_addr,        // register address
  input  logic [DATA_W-1:0] i_data,        // write data
  input  logic              i_busy,        // from capture
  input  logic [DATA_W-1:0] i_rx_data,     // last received byte
  output logic [DATA_W-1:0] o_data,        // registered read data
  output logic              o_ss_n,        // slave select, active low
  output logic              o_rd_data_in,  // data in being read
  spi_xfer_if.ctrl          xfer           // request side of handshake
);

  logic [DATA_W-1:0] ctrl_q;    // control register
  logic [DATA_W-1:0] tx_q;      // data out register
  logic              req_q;     // handshake request
  logic              wr_strb;   // bus write
  logic              rd_strb;   // bus read
  logic              start;     // accepted data out write
  logic [DATA_W-1:0] status_w;  // status word
  logic [DATA_W-1:0] rd_mux;    // read data before register

  assign wr_strb = i_en & i_wr;
  assign rd_strb = i_en & ~i_wr;

  // only start with ss enabled and the previous handshake fully closed
  assign start = wr_strb && (i_addr == ADDR_DATA_OUT) &&
                 ctrl_q[CTRL_SS_BIT] && !i_busy;

  assign o_rd_data_in = rd_strb && (i_addr == ADDR_DATA_IN);  // clears irq

  // control register, frozen during a transfer so the mode stays stable
  always_ff @(posedge i_clk or negedge i_sclk) begin
    if (!i_sclk) begin
      ctrl_q <= '0;
    end else if (wr_strb && (i_addr == ADDR_CTRL) && !i_busy) begin
      ctrl_q <= i_data;
    end
  end

  always_ff @(posedge i_clk) begin
    if (start) begin
      tx_q <= i_data;  // held until next accepted write
    end
  end

  // request side: raise on start, drop once ack seen
  always_ff @(posedge i_clk or negedge i_sclk) begin
    if (!i_sclk) begin
      req_q <= 1'b0;
    end else if (start) begin
      req_q <= 1'b1;
    end else if (xfer.ack) begin
      req_q <= 1'b0;  // phase 3
    end
  end

  always_comb begin
    status_w                  = '0;
    status_w[STATUS_BUSY_BIT] = i_busy;
    case (i_addr)
      ADDR_STATUS:   rd_mux = status_w;
      ADDR_DATA_OUT: rd_mux = tx_q;
      ADDR_DATA_IN:  rd_mux = i_rx_data;
      ADDR_CTRL:     rd_mux = ctrl_q;
      default:       rd_mux = '0;  // reserved
    endcase
  end

  always_ff @(posedge i_clk or negedge i_sclk) begin
    if (!i_sclk) begin
      o_data <= '0;
    end else if (rd_strb) begin
      o_data <= rd_mux;  // holds last read otherwise
    end
  end

  assign o_ss_n       = ~ctrl_q[CTRL_SS_BIT];
  assign xfer.req     = req_q;
  assign xfer.tx_byte = tx_q;
  assign xfer.cpol    = ctrl_q[CTRL_CPOL_BIT];
  assign xfer.cpha    = ctrl_q[CTRL_CPHA_BIT];
  assign xfer.clk_div = ctrl_q[CTRL_DIV_MSB:CTRL_DIV_LSB];

endmodule

// File: verilog/spi_xfer_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// four-phase req/ack link for one byte transfer
// mode and tx byte must hold while req is high
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

interface spi_xfer_if
  import spi_pkg::*;
();

  logic              req;      // transfer request from decode
  logic              ack;      // transfer done from engine
  logic [DATA_W-1:0] tx_byte;  // byte to shift out
  logic [DATA_W-1:0] rx_byte;  // byte shifted in, valid with ack
  logic              cpol;     // sclk idle level
  logic              cpha;     // sample on trailing edge when set
  logic [DIV_W-1:0]  clk_div;  // half period is clk_div+1 clocks

  // register side, owns the request
  modport ctrl (
    output req, tx_byte, cpol, cpha, clk_div,
    input  ack
  );

  // shift engine, owns the acknowledge
  modport eng (
    input  req, tx_byte, cpol, cpha, clk_div,
    output ack, rx_byte
  );

  // observer only
  modport mon (
    input req, ack, rx_byte
  );

endinterface

// File: verilog/spi_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared constants for the byte-wide spi master
// register map is 4 addresses, upper ones reserved
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package spi_pkg;

  // widths
  localparam int DATA_W    = 8;  // one spi byte
  localparam int ADDR_W    = 4;  // cpu register address
  localparam int DIV_W     = 5;  // clock divider field
  localparam int BIT_CNT_W = 4;  // counts 16 sclk edges

  // cpu register map
  localparam logic [ADDR_W-1:0] ADDR_STATUS   = 4'h0;  // busy flag
  localparam logic [ADDR_W-1:0] ADDR_DATA_OUT = 4'h1;  // byte to slave
  localparam logic [ADDR_W-1:0] ADDR_DATA_IN  = 4'h2;  // byte from slave
  localparam logic [ADDR_W-1:0] ADDR_CTRL     = 4'h3;  // mode, ss, divider

  // control register fields
  localparam int CTRL_CPHA_BIT = 0;  // clock phase
  localparam int CTRL_CPOL_BIT = 1;  // clock polarity
  localparam int CTRL_SS_BIT   = 2;  // slave select / spi enable
  localparam int CTRL_DIV_LSB  = 3;  // divider low bit
  localparam int CTRL_DIV_MSB  = 7;  // divider high bit

  // status register fields
  localparam int STATUS_BUSY_BIT = 0;  // transfer in flight

  // edge index of the final sclk edge in a byte
  localparam logic [BIT_CNT_W-1:0] LAST_EDGE = BIT_CNT_W'(2 * DATA_W - 1);

  // shift engine state encoding
  localparam int ST_W = 2;
  localparam logic [ST_W-1:0] ST_IDLE  = 2'd0;  // waiting for req
  localparam logic [ST_W-1:0] ST_SHIFT = 2'd1;  // toggling sclk
  localparam logic [ST_W-1:0] ST_DONE  = 2'd2;  // one cycle after last edge
  localparam logic [ST_W-1:0] ST_ACK   = 2'd3;  // ack high, wait req low

endpackage
